/* yolo_write_pkg.sv */
package yolo_write_pkg;

   localparam int IO_ADDR_W     = 32;
   localparam int HALF_ADDR_W   = 16;
   localparam int AXI_LEN_W     = 8;
   localparam int PIXEL_ADDR_W  = 10;
   // top bit selects the ping-pong bank
   localparam int VWRITE_ADDR_W = 9;
   localparam int N_STAGES      = 4;
   localparam int CFG_ADDR_W    = 5;

   typedef logic [IO_ADDR_W-1:0]     io_addr_t;
   typedef logic [HALF_ADDR_W-1:0]   half_addr_t;
   typedef logic [AXI_LEN_W-1:0]     axi_len_t;
   typedef logic [PIXEL_ADDR_W-1:0]  pixel_addr_t;
   typedef logic [VWRITE_ADDR_W-1:0] vwrite_addr_t;
   typedef logic [CFG_ADDR_W-1:0]    cfg_addr_t;

   // index 0 holds the base address
   typedef io_addr_t [N_STAGES-1:0] stage_addr_t;

   // configuration register map
   localparam cfg_addr_t VWRITE_CONF_EXT_ADDR = 5'd0;
   localparam cfg_addr_t VWRITE_CONF_OFFSET   = 5'd1;
   localparam cfg_addr_t VWRITE_CONF_LEN      = 5'd2;
   localparam cfg_addr_t VWRITE_CONF_INT_ADDR = 5'd3;
   localparam cfg_addr_t VWRITE_CONF_ITER_A   = 5'd4;
   localparam cfg_addr_t VWRITE_CONF_START_B  = 5'd5;
   localparam cfg_addr_t VWRITE_CONF_DUTY_B   = 5'd6;
   localparam cfg_addr_t VWRITE_CONF_DELAY_B  = 5'd7;
   localparam cfg_addr_t VWRITE_CONF_ITER_B   = 5'd8;
   localparam cfg_addr_t VWRITE_CONF_PER_B    = 5'd9;
   localparam cfg_addr_t VWRITE_CONF_SHIFT_B  = 5'd10;
   localparam cfg_addr_t VWRITE_CONF_INCR_B   = 5'd11;
   localparam cfg_addr_t VREAD_CONF_EXT_ADDR  = 5'd12;
   localparam cfg_addr_t VREAD_CONF_OFFSET    = 5'd13;
   localparam cfg_addr_t VREAD_CONF_LEN       = 5'd14;

   typedef struct packed {
      logic      valid;
      cfg_addr_t addr;
      io_addr_t  wdata;
      logic      wstrb;
   } cpu_req_t;

   // start only ever holds a vwrite buffer address
   typedef struct packed {
      pixel_addr_t start;
      pixel_addr_t duty;
      pixel_addr_t delay;
      pixel_addr_t iter;
      pixel_addr_t per;
      pixel_addr_t shift;
      pixel_addr_t incr;
   } pixgen_cfg_t;

   typedef struct packed {
      io_addr_t     ext_addr;
      half_addr_t   offset;
      axi_len_t     len;
      vwrite_addr_t int_addr;
      pixel_addr_t  iter_a;
      pixgen_cfg_t  gen;
   } vwrite_cfg_t;

   typedef struct packed {
      io_addr_t   ext_addr;
      half_addr_t offset;
      half_addr_t len;
   } vread_cfg_t;

   typedef struct packed {
      axi_len_t vwrite;
      axi_len_t vread;
   } dma_len_t;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } addrgen_state_e;

endpackage

/* yolo_cfg_regs.sv */
`timescale 1ns/100ps

module yolo_cfg_regs (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        clear,
   input  yolo_write_pkg::cpu_req_t    cpu,
   output yolo_write_pkg::vwrite_cfg_t vwrite_cfg,
   output yolo_write_pkg::vread_cfg_t  vread_cfg
);

   logic wr_en;

   assign wr_en = cpu.valid & cpu.wstrb;

   // clear wipes the live set between layers
   always_ff @(posedge clk, posedge rst, posedge clear) begin
      if (rst || clear) begin
         vwrite_cfg <= '0;
         vread_cfg  <= '0;
      end else if (wr_en) begin
         case (cpu.addr)
            yolo_write_pkg::VWRITE_CONF_EXT_ADDR: begin
               vwrite_cfg.ext_addr <= cpu.wdata;
            end
            yolo_write_pkg::VWRITE_CONF_OFFSET: begin
               vwrite_cfg.offset <= cpu.wdata[yolo_write_pkg::HALF_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_LEN: begin
               vwrite_cfg.len <= cpu.wdata[yolo_write_pkg::AXI_LEN_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_INT_ADDR: begin
               vwrite_cfg.int_addr <= cpu.wdata[yolo_write_pkg::VWRITE_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_ITER_A: begin
               vwrite_cfg.iter_a <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            // start is a buffer address, upper bit stays zero
            yolo_write_pkg::VWRITE_CONF_START_B: begin
               vwrite_cfg.gen.start <= yolo_write_pkg::pixel_addr_t'(
                  cpu.wdata[yolo_write_pkg::VWRITE_ADDR_W-1:0]);
            end
            yolo_write_pkg::VWRITE_CONF_DUTY_B: begin
               vwrite_cfg.gen.duty <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_DELAY_B: begin
               vwrite_cfg.gen.delay <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_ITER_B: begin
               vwrite_cfg.gen.iter <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_PER_B: begin
               vwrite_cfg.gen.per <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_SHIFT_B: begin
               vwrite_cfg.gen.shift <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VWRITE_CONF_INCR_B: begin
               vwrite_cfg.gen.incr <= cpu.wdata[yolo_write_pkg::PIXEL_ADDR_W-1:0];
            end
            yolo_write_pkg::VREAD_CONF_EXT_ADDR: begin
               vread_cfg.ext_addr <= cpu.wdata;
            end
            yolo_write_pkg::VREAD_CONF_OFFSET: begin
               vread_cfg.offset <= cpu.wdata[yolo_write_pkg::HALF_ADDR_W-1:0];
            end
            yolo_write_pkg::VREAD_CONF_LEN: begin
               vread_cfg.len <= cpu.wdata[yolo_write_pkg::HALF_ADDR_W-1:0];
            end
            // unmapped addresses fall through
            default: begin
            end
         endcase
      end
   end

endmodule

/* yolo_cfg_shadow.sv */
`timescale 1ns/100ps

module yolo_cfg_shadow (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run,
   input  yolo_write_pkg::vwrite_cfg_t  vwrite_cfg,
   input  yolo_write_pkg::vread_cfg_t   vread_cfg,
   output yolo_write_pkg::vwrite_cfg_t  vwrite_shadow,
   output yolo_write_pkg::half_addr_t   vread_len_shadow,
   output yolo_write_pkg::stage_addr_t  vwrite_ext_addr,
   output yolo_write_pkg::stage_addr_t  vread_ext_addr,
   output yolo_write_pkg::vwrite_addr_t vwrite_int_addr
);

   // vwrite chain, one step per run
   yolo_write_pkg::vwrite_cfg_t  vwrite_pipe0;
   yolo_write_pkg::vwrite_cfg_t  vwrite_pipe1;
   yolo_write_pkg::stage_addr_t  vwrite_ext_pipe0;
   yolo_write_pkg::stage_addr_t  vwrite_ext_pipe1;
   yolo_write_pkg::vwrite_addr_t vwrite_int_pipe0;
   yolo_write_pkg::vwrite_addr_t vwrite_int_pipe1;

   logic bank_next;

   // base + i * offset for every stage
   function automatic yolo_write_pkg::stage_addr_t stage_addrs(
      input yolo_write_pkg::io_addr_t   base,
      input yolo_write_pkg::half_addr_t offset
   );
      yolo_write_pkg::stage_addr_t addrs;
      for (int i = 0; i < yolo_write_pkg::N_STAGES; i++) begin
         addrs[i] = base + yolo_write_pkg::io_addr_t'(i) * offset;
      end
      return addrs;
   endfunction

   // ping-pong: flip the bank whenever the incoming layer has iterations
   assign bank_next = vwrite_int_pipe0[yolo_write_pkg::VWRITE_ADDR_W-1] ^ (|vwrite_cfg.iter_a);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         vwrite_pipe0     <= '0;
         vwrite_pipe1     <= '0;
         vwrite_shadow    <= '0;
         vwrite_ext_pipe0 <= '0;
         vwrite_ext_pipe1 <= '0;
         vwrite_ext_addr  <= '0;
         vwrite_int_pipe0 <= '0;
         vwrite_int_pipe1 <= '0;
         vwrite_int_addr  <= '0;
      end else if (run) begin
         vwrite_pipe0     <= vwrite_cfg;
         vwrite_pipe1     <= vwrite_pipe0;
         vwrite_shadow    <= vwrite_pipe1;
         vwrite_ext_pipe0 <= stage_addrs(vwrite_cfg.ext_addr, vwrite_cfg.offset);
         vwrite_ext_pipe1 <= vwrite_ext_pipe0;
         vwrite_ext_addr  <= vwrite_ext_pipe1;
         vwrite_int_pipe0 <= {bank_next,
                              vwrite_cfg.int_addr[yolo_write_pkg::VWRITE_ADDR_W-2:0]};
         vwrite_int_pipe1 <= vwrite_int_pipe0;
         vwrite_int_addr  <= vwrite_int_pipe1;
      end
   end

   // vread config is used by the very next run
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         vread_len_shadow <= '0;
         vread_ext_addr   <= '0;
      end else if (run) begin
         vread_len_shadow <= vread_cfg.len;
         vread_ext_addr   <= stage_addrs(vread_cfg.ext_addr, vread_cfg.offset);
      end
   end

endmodule

/* yolo_dma_len.sv */
`timescale 1ns/100ps

module yolo_dma_len (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  logic                       vread_ready,
   input  yolo_write_pkg::half_addr_t vread_len,
   input  yolo_write_pkg::half_addr_t vread_len_shadow,
   output yolo_write_pkg::axi_len_t   vread_dma_len
);

   yolo_write_pkg::half_addr_t dma_cnt;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         dma_cnt <= '0;
      end else if (run) begin
         dma_cnt <= vread_len;
      end else if (vread_ready) begin
         // wrap back to the layer length once exhausted
         if (dma_cnt == '0) begin
            dma_cnt <= vread_len_shadow;
         end else begin
            dma_cnt <= dma_cnt - 1'b1;
         end
      end
   end

   // clamp to the longest axi burst
   assign vread_dma_len = (|dma_cnt[yolo_write_pkg::HALF_ADDR_W-1:yolo_write_pkg::AXI_LEN_W])
                          ? '1 : dma_cnt[yolo_write_pkg::AXI_LEN_W-1:0];

endmodule

/* yolo_pixel_addrgen.sv */
`timescale 1ns/100ps

module yolo_pixel_addrgen (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run_q,
   input  yolo_write_pkg::pixgen_cfg_t cfg,
   output yolo_write_pkg::pixel_addr_t pix_addr,
   output logic                        pix_en,
   output logic                        done
);

   yolo_write_pkg::addrgen_state_e state;
   yolo_write_pkg::pixel_addr_t    delay_cnt;
   yolo_write_pkg::pixel_addr_t    per_cnt;
   yolo_write_pkg::pixel_addr_t    iter_cnt;

   logic start_gen;
   logic delay_last;
   logic per_last;
   logic iter_last;

   assign start_gen  = run_q && (cfg.iter != '0);
   assign delay_last = (delay_cnt + 1'b1) >= cfg.delay;
   // per of zero behaves like a period of one
   assign per_last   = (per_cnt + 1'b1) >= cfg.per;
   assign iter_last  = (iter_cnt + 1'b1) >= cfg.iter;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state     <= yolo_write_pkg::GEN_IDLE;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
      end else if (run_q) begin
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         if (cfg.iter == '0) begin
            state <= yolo_write_pkg::GEN_IDLE;
         end else if (cfg.delay == '0) begin
            state <= yolo_write_pkg::GEN_RUN;
         end else begin
            state <= yolo_write_pkg::GEN_DELAY;
         end
      end else begin
         case (state)
            yolo_write_pkg::GEN_DELAY: begin
               if (delay_last) begin
                  state <= yolo_write_pkg::GEN_RUN;
               end else begin
                  delay_cnt <= delay_cnt + 1'b1;
               end
            end
            yolo_write_pkg::GEN_RUN: begin
               if (per_last) begin
                  per_cnt <= '0;
                  if (iter_last) begin
                     state <= yolo_write_pkg::GEN_IDLE;
                  end else begin
                     iter_cnt <= iter_cnt + 1'b1;
                  end
               end else begin
                  per_cnt <= per_cnt + 1'b1;
               end
            end
            default: begin
            end
         endcase
      end
   end

   // address walk, shift replaces incr at the period boundary
   always_ff @(posedge clk) begin
      if (start_gen) begin
         pix_addr <= cfg.start;
      end else if (state == yolo_write_pkg::GEN_RUN) begin
         pix_addr <= pix_addr + (per_last ? cfg.shift : cfg.incr);
      end
   end

   assign pix_en = (state == yolo_write_pkg::GEN_RUN) && (per_cnt < cfg.duty);
   assign done   = (state == yolo_write_pkg::GEN_IDLE);

endmodule

/* yolo_write_ctrl.sv */
`timescale 1ns/100ps

module yolo_write_ctrl (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clear,
   input  logic                         run,
   input  yolo_write_pkg::cpu_req_t     cpu,
   input  logic                         vread_ready,
   output logic                         done,
   output yolo_write_pkg::dma_len_t     dma_len,
   output yolo_write_pkg::stage_addr_t  vwrite_ext_addr,
   output yolo_write_pkg::stage_addr_t  vread_ext_addr,
   output yolo_write_pkg::vwrite_addr_t vwrite_int_addr,
   output yolo_write_pkg::pixel_addr_t  pix_addr,
   output logic                         pix_en
);

   yolo_write_pkg::vwrite_cfg_t vwrite_cfg;
   yolo_write_pkg::vread_cfg_t  vread_cfg;
   yolo_write_pkg::vwrite_cfg_t vwrite_shadow;
   yolo_write_pkg::half_addr_t  vread_len_shadow;
   yolo_write_pkg::axi_len_t    vread_dma_len;
   logic                        run_q;

   // generator starts once the shadow has settled
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         run_q <= 1'b0;
      end else begin
         run_q <= run;
      end
   end

   yolo_cfg_regs cfg_regs_inst (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .cpu        (cpu),
      .vwrite_cfg (vwrite_cfg),
      .vread_cfg  (vread_cfg)
   );

   yolo_cfg_shadow cfg_shadow_inst (
      .clk              (clk),
      .rst              (rst),
      .run              (run),
      .vwrite_cfg       (vwrite_cfg),
      .vread_cfg        (vread_cfg),
      .vwrite_shadow    (vwrite_shadow),
      .vread_len_shadow (vread_len_shadow),
      .vwrite_ext_addr  (vwrite_ext_addr),
      .vread_ext_addr   (vread_ext_addr),
      .vwrite_int_addr  (vwrite_int_addr)
   );

   yolo_dma_len dma_len_inst (
      .clk              (clk),
      .rst              (rst),
      .run              (run),
      .vread_ready      (vread_ready),
      .vread_len        (vread_cfg.len),
      .vread_len_shadow (vread_len_shadow),
      .vread_dma_len    (vread_dma_len)
   );

   yolo_pixel_addrgen pixel_addrgen_inst (
      .clk      (clk),
      .rst      (rst),
      .run_q    (run_q),
      .cfg      (vwrite_shadow.gen),
      .pix_addr (pix_addr),
      .pix_en   (pix_en),
      .done     (done)
   );

   assign dma_len.vwrite = vwrite_shadow.len;
   assign dma_len.vread  = vread_dma_len;

endmodule

/* yolo_write_checker.sv */
`timescale 1ns/100ps

module yolo_write_checker (
   input logic clk,
   input logic rst,
   input logic run_q,
   input logic pix_en,
   input logic done
);

   int fail_count = 0;

   // an idle generator never enables a write
   en_while_idle: assert property (@(posedge clk) disable iff (rst) !(pix_en && done))
   else begin
      $error("pix_en high while done is high");
      fail_count++;
   end

   // only a start request takes the generator busy
   done_fall: assert property (@(posedge clk) disable iff (rst) $fell(done) |-> $past(run_q))
   else begin
      $error("done fell without run_q in the previous cycle");
      fail_count++;
   end

   en_in_reset: assert property (@(posedge clk) rst |-> !pix_en)
   else begin
      $error("pix_en high during reset");
      fail_count++;
   end

endmodule

bind yolo_pixel_addrgen yolo_write_checker write_checker_inst (
   .clk    (clk),
   .rst    (rst),
   .run_q  (run_q),
   .pix_en (pix_en),
   .done   (done)
);

/* tb_yolo_write_ctrl.sv */
`timescale 1ns/100ps

module tb_yolo_write_ctrl;

   // bases, offsets and lengths are filled in from $random
   typedef struct packed {
      yolo_write_pkg::pixgen_cfg_t  gen;
      yolo_write_pkg::pixel_addr_t  iter_a;
      yolo_write_pkg::vwrite_addr_t int_addr;
      logic                         do_clear;
      int                           ready_cycles;
      int                           exp_pix;
   } row_t;

   logic                         clk;
   logic                         rst;
   logic                         clear;
   logic                         run;
   yolo_write_pkg::cpu_req_t     cpu;
   logic                         vread_ready;
   logic                         done;
   yolo_write_pkg::dma_len_t     dma_len;
   yolo_write_pkg::stage_addr_t  vwrite_ext_addr;
   yolo_write_pkg::stage_addr_t  vread_ext_addr;
   yolo_write_pkg::vwrite_addr_t vwrite_int_addr;
   yolo_write_pkg::pixel_addr_t  pix_addr;
   logic                         pix_en;

   integer seed;
   row_t   rows [6];

   // reference model, entry 2 of each chain is the shadow
   yolo_write_pkg::vwrite_cfg_t  live_vw;
   yolo_write_pkg::vread_cfg_t   live_vr;
   yolo_write_pkg::vwrite_cfg_t  m_vw [3];
   yolo_write_pkg::stage_addr_t  m_ext [3];
   yolo_write_pkg::vwrite_addr_t m_int [3];
   yolo_write_pkg::stage_addr_t  m_vr_ext;
   yolo_write_pkg::half_addr_t   m_vr_len;
   yolo_write_pkg::half_addr_t   m_cnt;
   logic                         m_bank;
   yolo_write_pkg::pixel_addr_t  exp_q [$];
   yolo_write_pkg::pixel_addr_t  got_q [$];

   yolo_write_ctrl yolo_write_ctrl_inst (.*);

   always #20 clk = ~clk;

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         $display("Something failed");
         $fatal(1);
      end
   endtask

   task automatic abort_wait(input string what);
      $display("timed out waiting for %s", what);
      $display("Something failed");
      $fatal(1);
   endtask

   function automatic yolo_write_pkg::stage_addr_t stage_chain(
      input yolo_write_pkg::io_addr_t base, input yolo_write_pkg::half_addr_t offset);
      yolo_write_pkg::stage_addr_t addrs;
      yolo_write_pkg::io_addr_t    a;
      a = base;
      for (int i = 0; i < yolo_write_pkg::N_STAGES; i++) begin
         addrs[i] = a;
         a = a + 32'(offset);
      end
      return addrs;
   endfunction

   function automatic yolo_write_pkg::axi_len_t burst_limit(
      input yolo_write_pkg::half_addr_t n);
      return (n > 16'd255) ? 8'hff : n[7:0];
   endfunction

   task automatic write_reg(input yolo_write_pkg::cfg_addr_t addr,
                            input yolo_write_pkg::io_addr_t data);
      cpu.valid = 1'b1;
      cpu.wstrb = 1'b1;
      cpu.addr  = addr;
      cpu.wdata = data;
      @(negedge clk);
      cpu = '0;
   endtask

   task automatic program_row(input row_t row);
      live_vw.ext_addr = $random(seed);
      live_vw.offset   = yolo_write_pkg::half_addr_t'($random(seed));
      live_vw.len      = yolo_write_pkg::axi_len_t'($random(seed));
      live_vw.int_addr = row.int_addr;
      live_vw.iter_a   = row.iter_a;
      live_vw.gen      = row.gen;
      live_vr.ext_addr = $random(seed);
      live_vr.offset   = yolo_write_pkg::half_addr_t'($random(seed));
      // always above 255 so the burst clamp is visible
      live_vr.len      = 16'd256 + yolo_write_pkg::half_addr_t'($random(seed) & 32'h3f);
      write_reg(yolo_write_pkg::VWRITE_CONF_EXT_ADDR, live_vw.ext_addr);
      write_reg(yolo_write_pkg::VWRITE_CONF_OFFSET, 32'(live_vw.offset));
      write_reg(yolo_write_pkg::VWRITE_CONF_LEN, 32'(live_vw.len));
      write_reg(yolo_write_pkg::VWRITE_CONF_INT_ADDR, 32'(live_vw.int_addr));
      write_reg(yolo_write_pkg::VWRITE_CONF_ITER_A, 32'(live_vw.iter_a));
      write_reg(yolo_write_pkg::VWRITE_CONF_START_B, 32'(live_vw.gen.start));
      write_reg(yolo_write_pkg::VWRITE_CONF_DUTY_B, 32'(live_vw.gen.duty));
      write_reg(yolo_write_pkg::VWRITE_CONF_DELAY_B, 32'(live_vw.gen.delay));
      write_reg(yolo_write_pkg::VWRITE_CONF_ITER_B, 32'(live_vw.gen.iter));
      write_reg(yolo_write_pkg::VWRITE_CONF_PER_B, 32'(live_vw.gen.per));
      write_reg(yolo_write_pkg::VWRITE_CONF_SHIFT_B, 32'(live_vw.gen.shift));
      write_reg(yolo_write_pkg::VWRITE_CONF_INCR_B, 32'(live_vw.gen.incr));
      write_reg(yolo_write_pkg::VREAD_CONF_EXT_ADDR, live_vr.ext_addr);
      write_reg(yolo_write_pkg::VREAD_CONF_OFFSET, 32'(live_vr.offset));
      write_reg(yolo_write_pkg::VREAD_CONF_LEN, 32'(live_vr.len));
   endtask

   task automatic pulse_run;
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      for (int k = 2; k > 0; k--) begin
         m_vw[k]  = m_vw[k-1];
         m_ext[k] = m_ext[k-1];
         m_int[k] = m_int[k-1];
      end
      // bank flips when the layer being latched has iterations
      m_bank   = m_bank ^ (live_vw.iter_a != '0);
      m_vw[0]  = live_vw;
      m_ext[0] = stage_chain(live_vw.ext_addr, live_vw.offset);
      m_int[0] = {m_bank, live_vw.int_addr[7:0]};
      m_vr_ext = stage_chain(live_vr.ext_addr, live_vr.offset);
      m_vr_len = live_vr.len;
      m_cnt    = live_vr.len;
      check_value("vread_ext_addr", vread_ext_addr, m_vr_ext);
      check_value("vwrite_ext_addr", vwrite_ext_addr, m_ext[2]);
      check_value("vwrite_int_addr", vwrite_int_addr, m_int[2]);
      check_value("dma_len.vwrite", dma_len.vwrite, m_vw[2].len);
      check_value("dma_len.vread", dma_len.vread, burst_limit(m_cnt));
   endtask

   task automatic verify_pixels(input int exp_count);
      yolo_write_pkg::pixgen_cfg_t g;
      yolo_write_pkg::pixel_addr_t a;
      int t;
      g = m_vw[2].gen;
      a = g.start;
      exp_q.delete();
      got_q.delete();
      for (int i = 0; i < g.iter; i++) begin
         for (int p = 0; p < g.per; p++) begin
            if (p < g.duty) begin
               exp_q.push_back(a);
            end
            // last slot of a period moves by shift
            a = a + ((p == g.per - 1) ? g.shift : g.incr);
         end
      end
      if (g.iter == '0) begin
         repeat (4) begin
            @(negedge clk);
            check_value("done", done, 1'b1);
         end
      end else begin
         t = 0;
         while (done) begin
            if (t == 20) begin
               abort_wait("done to fall after run");
            end
            @(negedge clk);
            t++;
         end
         t = 0;
         while (!done) begin
            if (pix_en) begin
               got_q.push_back(pix_addr);
            end
            if (t == 5000) begin
               abort_wait("done to rise after the pixel sequence");
            end
            @(negedge clk);
            t++;
         end
         // busy for the delay plus every period
         check_value("busy cycles", t, int'(g.delay) + int'(g.iter) * int'(g.per));
      end
      check_value("pixel count", got_q.size(), exp_count);
      check_value("model pixel count", exp_q.size(), exp_count);
      foreach (got_q[i]) begin
         check_value($sformatf("pix_addr[%0d]", i), got_q[i], exp_q[i]);
      end
   endtask

   task automatic pace_vread(input int cycles);
      vread_ready = 1'b1;
      for (int c = 0; c < cycles; c++) begin
         @(negedge clk);
         m_cnt = (m_cnt == '0) ? m_vr_len : m_cnt - 1'b1;
         check_value("dma_len.vread", dma_len.vread, burst_limit(m_cnt));
      end
      vread_ready = 1'b0;
   endtask

   initial begin
      seed        = 32'h663d;
      clk         = 1'b0;
      rst         = 1'b1;
      clear       = 1'b0;
      run         = 1'b0;
      cpu         = '0;
      vread_ready = 1'b0;
      m_vw        = '{default: '0};
      m_ext       = '{default: '0};
      m_int       = '{default: '0};
      m_bank      = 1'b0;
      // {start, duty, delay, iter, per, shift, incr}, iter_a, int_addr, clear,
      // vread_ready cycles, enabled pixels
      rows[0] = '{'{10'd10, 10'd3, 10'd0, 10'd2, 10'd4, 10'd20, 10'd1}, 10'd1, 9'h025, 1'b0, 5, 6};
      rows[1] = '{'{10'd100, 10'd2, 10'd3, 10'd3, 10'd2, 10'd5, 10'd7}, 10'd0, 9'h1f0, 1'b0, 330, 6};
      rows[2] = '{'{10'd500, 10'd5, 10'd1, 10'd1, 10'd5, 10'd0, 10'd3}, 10'd2, 9'h0aa, 1'b0, 3, 5};
      rows[3] = '{'{10'd7, 10'd4, 10'd2, 10'd2, 10'd3, 10'd1, 10'd2}, 10'd3, 9'h033, 1'b1, 4, 0};
      rows[4] = '{'{10'd20, 10'd1, 10'd0, 10'd4, 10'd2, 10'd2, 10'd1}, 10'd1, 9'h100, 1'b0, 2, 4};
      rows[5] = '{'{10'd0, 10'd1, 10'd0, 10'd1, 10'd1, 10'd0, 10'd0}, 10'd0, 9'h011, 1'b0, 2, 1};
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_value("done", done, 1'b1);
      check_value("pix_en", pix_en, 1'b0);
      check_value("dma_len", dma_len, '0);
      check_value("vwrite_ext_addr", vwrite_ext_addr, '0);
      check_value("vread_ext_addr", vread_ext_addr, '0);
      check_value("vwrite_int_addr", vwrite_int_addr, '0);
      foreach (rows[r]) begin
         program_row(rows[r]);
         if (rows[r].do_clear) begin
            clear = 1'b1;
            @(negedge clk);
            clear = 1'b0;
            live_vw = '0;
            live_vr = '0;
         end
         pulse_run();
         // the generator runs the layer written two rows back
         verify_pixels((r >= 2) ? rows[r-2].exp_pix : 0);
         pace_vread(rows[r].ready_cycles);
      end
      if (yolo_write_ctrl_inst.pixel_addrgen_inst.write_checker_inst.fail_count != 0) begin
         $display("the bound checker reported assertion failures");
         $display("Something failed");
         $fatal(1);
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

/* all.f */
yolo_write_pkg.sv
yolo_cfg_regs.sv
yolo_cfg_shadow.sv
yolo_dma_len.sv
yolo_pixel_addrgen.sv
yolo_write_ctrl.sv
yolo_write_checker.sv
tb_yolo_write_ctrl.sv
